// File: hdl/irq_pkg.sv
package irq_pkg;

  ////////////////////////////////////////////////////////////
  // interrupt line count
  ////////////////////////////////////////////////////////////

  // number of level-triggered interrupt lines
  localparam int unsigned IRQ_NUM = 32;

  ////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////

  // privilege levels, only user and machine are implemented
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // interrupt controller states
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    IRQ_PENDING = 2'd1,
    IRQ_DONE    = 2'd2
  } ctrl_state_e;

  // selectors for the small machine CSR space
  typedef enum logic [2:0] {
    CSR_STATUS   = 3'd0,
    CSR_MTVEC    = 3'd1,
    CSR_MEPC     = 3'd2,
    CSR_MCAUSE   = 3'd3,
    CSR_IRQ_MASK = 3'd4,
    CSR_IRQ_SEC  = 3'd5
  } csr_addr_e;

  ////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////

  // arbitrated request from the line arbiter
  typedef struct packed {
    logic       valid;
    logic       sec;
    logic [4:0] id;
  } irq_req_t;

  // status bits, mpp is reduced to a single machine-mode flag
  typedef struct packed {
    logic mie;
    logic uie;
    logic mpie;
    logic mpp_is_m;
  } status_t;

endpackage

// File: hdl/irq_line_arbiter.sv
`timescale 1ns/1ps

module irq_line_arbiter (
  input  logic [irq_pkg::IRQ_NUM-1:0] irq_lines_i,
  input  logic [irq_pkg::IRQ_NUM-1:0] irq_mask_i,
  input  logic [irq_pkg::IRQ_NUM-1:0] irq_sec_mask_i,
  output irq_pkg::irq_req_t           irq_req_o
);

  // lines that are both raised and unmasked
  logic [irq_pkg::IRQ_NUM-1:0] pending;
  // index of the winning line
  logic [4:0]                  sel_id;
  // at least one line pending
  logic                        any_pending;

  assign pending     = irq_lines_i & irq_mask_i;
  assign any_pending = |pending;

  ////////////////////////////////////////////////////////////
  // lowest-index priority search
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    sel_id = '0;
    // walk from the top down so the lowest pending line
    // is the last one to overwrite the selection
    for (int i = irq_pkg::IRQ_NUM - 1; i >= 0; i--)
    begin
      if (pending[i])
      begin
        sel_id = 5'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // request assembly
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    irq_req_o.valid = any_pending;
    irq_req_o.id    = sel_id;
    // secure attribute follows the selected line
    // only meaningful when valid is high
    irq_req_o.sec   = any_pending & irq_sec_mask_i[sel_id];
  end

endmodule

// File: hdl/irq_int_controller.sv
`timescale 1ns/1ps

module irq_int_controller #(
  parameter bit SECURE_EN = 1'b1
) (
  input  logic                clk,
  input  logic                rst_n,
  // arbitrated request from the line arbiter
  input  irq_pkg::irq_req_t   irq_req_i,
  // enable bits and current privilege from the CSR file
  input  irq_pkg::status_t    status_i,
  input  irq_pkg::priv_lvl_e  priv_lvl_i,
  // pulses back from the trap controller
  input  logic                ctrl_ack_i,
  input  logic                ctrl_kill_i,
  // request towards the trap controller
  output logic                irq_req_ctrl_o,
  output logic                irq_sec_ctrl_o,
  output logic [4:0]          irq_id_ctrl_o
);

  irq_pkg::ctrl_state_e state_q;
  logic                 irq_enable;
  logic                 accept;
  logic                 sec_q;
  logic [4:0]           id_q;

  ////////////////////////////////////////////////////////////
  // enable gating
  ////////////////////////////////////////////////////////////

  if (SECURE_EN)
  begin : g_secure
    // user mode takes uie or a secure line, machine mode takes mie
    assign irq_enable =
      ((status_i.uie | irq_req_i.sec) & (priv_lvl_i == irq_pkg::PRIV_LVL_U)) |
      (status_i.mie & (priv_lvl_i == irq_pkg::PRIV_LVL_M));
  end
  else
  begin : g_plain
    // global machine enable only
    assign irq_enable = status_i.mie;
  end

  // request taken on this edge
  assign accept = (state_q == irq_pkg::IDLE) & irq_req_i.valid & irq_enable;

  ////////////////////////////////////////////////////////////
  // pending / done state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= irq_pkg::IDLE;
      sec_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        irq_pkg::IDLE:
        begin
          if (accept)
          begin
            state_q <= irq_pkg::IRQ_PENDING;
            sec_q   <= irq_req_i.sec;
          end
        end
        irq_pkg::IRQ_PENDING:
        begin
          // hold until the core acks or kills
          if (ctrl_ack_i)
          begin
            state_q <= irq_pkg::IRQ_DONE;
          end
          else if (ctrl_kill_i)
          begin
            state_q <= irq_pkg::IDLE;
          end
        end
        irq_pkg::IRQ_DONE:
        begin
          // one cycle only, handler entry is complete
          sec_q   <= 1'b0;
          state_q <= irq_pkg::IDLE;
        end
        default:
        begin
          state_q <= irq_pkg::IDLE;
        end
      endcase
    end
  end

  // id captured with the request
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      id_q <= irq_req_i.id;
    end
  end

  assign irq_req_ctrl_o = (state_q == irq_pkg::IRQ_PENDING);
  assign irq_sec_ctrl_o = sec_q;
  assign irq_id_ctrl_o  = id_q;

endmodule

// File: hdl/irq_csr_file.sv
`timescale 1ns/1ps

module irq_csr_file (
  input  logic                        clk,
  input  logic                        rst_n,
  // software access
  input  logic                        csr_we_i,
  input  irq_pkg::csr_addr_e          csr_addr_i,
  input  logic [31:0]                 csr_wdata_i,
  output logic [31:0]                 csr_rdata_o,
  // trap entry and return
  input  logic                        trap_enter_i,
  input  logic [4:0]                  trap_cause_i,
  input  logic [31:0]                 pc_i,
  input  logic                        mret_i,
  // machine state towards the interrupt path
  output irq_pkg::status_t            status_o,
  output irq_pkg::priv_lvl_e          priv_lvl_o,
  output logic [31:0]                 mtvec_o,
  output logic [irq_pkg::IRQ_NUM-1:0] irq_mask_o,
  output logic [irq_pkg::IRQ_NUM-1:0] irq_sec_mask_o
);

  irq_pkg::status_t            status_q;
  irq_pkg::priv_lvl_e          priv_q;
  logic [31:0]                 mtvec_q;
  logic [31:0]                 mepc_q;
  logic [4:0]                  mcause_q;
  logic [irq_pkg::IRQ_NUM-1:0] mask_q;
  logic [irq_pkg::IRQ_NUM-1:0] sec_mask_q;
  logic [31:0]                 status_rdata;
  // software write strobes per register
  logic                        we_status;
  logic                        we_mepc;
  logic                        we_mcause;

  assign we_status = csr_we_i & (csr_addr_i == irq_pkg::CSR_STATUS);
  assign we_mepc   = csr_we_i & (csr_addr_i == irq_pkg::CSR_MEPC);
  assign we_mcause = csr_we_i & (csr_addr_i == irq_pkg::CSR_MCAUSE);

  ////////////////////////////////////////////////////////////
  // status and privilege
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      status_q <= '0;
      priv_q   <= irq_pkg::PRIV_LVL_M;
    end
    else if (trap_enter_i)
    begin
      // stack the enable and the old privilege
      status_q.mpie     <= status_q.mie;
      status_q.mie      <= 1'b0;
      status_q.mpp_is_m <= (priv_q == irq_pkg::PRIV_LVL_M);
      priv_q            <= irq_pkg::PRIV_LVL_M;
    end
    else if (mret_i)
    begin
      // unstack, mpp drops back to user as on a real core
      status_q.mie      <= status_q.mpie;
      status_q.mpie     <= 1'b1;
      status_q.mpp_is_m <= 1'b0;
      priv_q <= status_q.mpp_is_m ? irq_pkg::PRIV_LVL_M : irq_pkg::PRIV_LVL_U;
    end
    else if (we_status)
    begin
      // mstatus-like layout: uie 0, mie 3, mpie 7, mpp 12:11
      status_q.uie      <= csr_wdata_i[0];
      status_q.mie      <= csr_wdata_i[3];
      status_q.mpie     <= csr_wdata_i[7];
      status_q.mpp_is_m <= (csr_wdata_i[12:11] == 2'b11);
    end
  end

  ////////////////////////////////////////////////////////////
  // trap base and line masks
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mtvec_q    <= '0;
      mask_q     <= '0;
      sec_mask_q <= '0;
    end
    else if (csr_we_i & ~trap_enter_i)
    begin
      case (csr_addr_i)
        irq_pkg::CSR_MTVEC:    mtvec_q    <= csr_wdata_i;
        irq_pkg::CSR_IRQ_MASK: mask_q     <= csr_wdata_i;
        irq_pkg::CSR_IRQ_SEC:  sec_mask_q <= csr_wdata_i;
        default:               mtvec_q    <= mtvec_q;
      endcase
    end
  end

  // return pc and cause
  always_ff @(posedge clk)
  begin
    if (trap_enter_i)
    begin
      mepc_q   <= pc_i;
      mcause_q <= trap_cause_i;
    end
    else
    begin
      if (we_mepc)
      begin
        mepc_q <= csr_wdata_i;
      end
      if (we_mcause)
      begin
        mcause_q <= csr_wdata_i[4:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    status_rdata        = '0;
    status_rdata[0]     = status_q.uie;
    status_rdata[3]     = status_q.mie;
    status_rdata[7]     = status_q.mpie;
    status_rdata[12:11] = {2{status_q.mpp_is_m}};
  end

  always_comb
  begin
    case (csr_addr_i)
      irq_pkg::CSR_STATUS:   csr_rdata_o = status_rdata;
      irq_pkg::CSR_MTVEC:    csr_rdata_o = mtvec_q;
      irq_pkg::CSR_MEPC:     csr_rdata_o = mepc_q;
      irq_pkg::CSR_MCAUSE:   csr_rdata_o = {27'b0, mcause_q};
      irq_pkg::CSR_IRQ_MASK: csr_rdata_o = mask_q;
      irq_pkg::CSR_IRQ_SEC:  csr_rdata_o = sec_mask_q;
      default:               csr_rdata_o = '0;
    endcase
  end

  assign status_o       = status_q;
  assign priv_lvl_o     = priv_q;
  assign mtvec_o        = mtvec_q;
  assign irq_mask_o     = mask_q;
  assign irq_sec_mask_o = sec_mask_q;

endmodule

// File: hdl/irq_trap_ctrl.sv
`timescale 1ns/1ps

module irq_trap_ctrl (
  input  logic        clk,
  input  logic        rst_n,
  // request from the interrupt controller
  input  logic        irq_req_ctrl_i,
  input  logic [4:0]  irq_id_ctrl_i,
  // core state
  input  logic        busy_i,
  input  logic        flush_i,
  // trap base from the CSR file
  input  logic [31:0] mtvec_i,
  // pulses back to the interrupt controller
  output logic        ctrl_ack_o,
  output logic        ctrl_kill_o,
  // jump to the handler
  output logic        trap_valid_o,
  output logic [31:0] trap_target_o,
  output logic [4:0]  trap_cause_o
);

  logic        ack;
  logic        kill;
  logic [31:0] vec_target;
  logic        trap_valid_q;
  logic [31:0] trap_target_q;
  logic [4:0]  trap_cause_q;

  ////////////////////////////////////////////////////////////
  // ack / kill decision
  ////////////////////////////////////////////////////////////

  // a flush drops the request, the pipeline is being redirected
  assign kill = irq_req_ctrl_i & flush_i;

  // accept only when the core can take the jump this cycle
  // busy stretches the pending state
  assign ack  = irq_req_ctrl_i & ~busy_i & ~flush_i;

  assign ctrl_ack_o  = ack;
  assign ctrl_kill_o = kill;

  ////////////////////////////////////////////////////////////
  // vectored jump
  ////////////////////////////////////////////////////////////

  // one word per vector slot
  assign vec_target = mtvec_i + {25'b0, irq_id_ctrl_i, 2'b00};

  // trap strobe, one cycle per ack
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      trap_valid_q <= 1'b0;
    end
    else
    begin
      trap_valid_q <= ack;
    end
  end

  // target and cause travel with the strobe
  always_ff @(posedge clk)
  begin
    if (ack)
    begin
      trap_target_q <= vec_target;
      trap_cause_q  <= irq_id_ctrl_i;
    end
  end

  assign trap_valid_o  = trap_valid_q;
  assign trap_target_o = trap_target_q;
  assign trap_cause_o  = trap_cause_q;

endmodule

// File: hdl/irq_subsys_top.sv
`timescale 1ns/1ps

module irq_subsys_top #(
  parameter bit SECURE_EN = 1'b1
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [irq_pkg::IRQ_NUM-1:0] irq_lines_i,
  // core state
  input  logic                        busy_i,
  input  logic                        flush_i,
  input  logic [31:0]                 pc_i,
  input  logic                        mret_i,
  // CSR access
  input  logic                        csr_we_i,
  input  irq_pkg::csr_addr_e          csr_addr_i,
  input  logic [31:0]                 csr_wdata_i,
  output logic [31:0]                 csr_rdata_o,
  // handler entry
  output logic                        trap_valid_o,
  output logic [31:0]                 trap_target_o,
  output logic [4:0]                  trap_cause_o,
  output irq_pkg::priv_lvl_e          priv_lvl_o
);

  irq_pkg::irq_req_t           irq_req;
  irq_pkg::status_t            status;
  irq_pkg::priv_lvl_e          priv_lvl;
  logic [31:0]                 mtvec;
  logic [irq_pkg::IRQ_NUM-1:0] irq_mask;
  logic [irq_pkg::IRQ_NUM-1:0] irq_sec_mask;
  logic                        irq_req_ctrl;
  logic [4:0]                  irq_id_ctrl;
  logic                        ctrl_ack;
  logic                        ctrl_kill;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  irq_line_arbiter u_irq_line_arbiter (
    .irq_lines_i    (irq_lines_i),
    .irq_mask_i     (irq_mask),
    .irq_sec_mask_i (irq_sec_mask),
    .irq_req_o      (irq_req)
  );

  // secure flag of the latched request has no consumer here
  irq_int_controller #(
    .SECURE_EN (SECURE_EN)
  ) u_irq_int_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_req_i      (irq_req),
    .status_i       (status),
    .priv_lvl_i     (priv_lvl),
    .ctrl_ack_i     (ctrl_ack),
    .ctrl_kill_i    (ctrl_kill),
    .irq_req_ctrl_o (irq_req_ctrl),
    .irq_sec_ctrl_o (),
    .irq_id_ctrl_o  (irq_id_ctrl)
  );

  irq_trap_ctrl u_irq_trap_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_req_ctrl_i (irq_req_ctrl),
    .irq_id_ctrl_i  (irq_id_ctrl),
    .busy_i         (busy_i),
    .flush_i        (flush_i),
    .mtvec_i        (mtvec),
    .ctrl_ack_o     (ctrl_ack),
    .ctrl_kill_o    (ctrl_kill),
    .trap_valid_o   (trap_valid_o),
    .trap_target_o  (trap_target_o),
    .trap_cause_o   (trap_cause_o)
  );

  ////////////////////////////////////////////////////////////
  // machine state
  ////////////////////////////////////////////////////////////

  // ack doubles as the trap-entry strobe
  irq_csr_file u_irq_csr_file (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_we_i       (csr_we_i),
    .csr_addr_i     (csr_addr_i),
    .csr_wdata_i    (csr_wdata_i),
    .csr_rdata_o    (csr_rdata_o),
    .trap_enter_i   (ctrl_ack),
    .trap_cause_i   (irq_id_ctrl),
    .pc_i           (pc_i),
    .mret_i         (mret_i),
    .status_o       (status),
    .priv_lvl_o     (priv_lvl),
    .mtvec_o        (mtvec),
    .irq_mask_o     (irq_mask),
    .irq_sec_mask_o (irq_sec_mask)
  );

  assign priv_lvl_o = priv_lvl;

endmodule

// File: tb/irq_subsys_assertions.sv
`timescale 1ns/1ps

module irq_subsys_assertions (
  input logic clk,
  input logic rst_n,
  // request level and the two answers
  input logic req_i,
  input logic ack_i,
  input logic kill_i,
  // one-cycle completion marker of the bound block
  input logic done_i
);

  ////////////////////////////////////////////////////////////
  // request exchange
  ////////////////////////////////////////////////////////////

  // core answers a request one way only
  ack_kill_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ack_i && kill_i)
  ) else $error("ack and kill high in the same cycle");

  // request held through back-pressure
  req_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    req_i && !ack_i && !kill_i |=> req_i
  ) else $error("request dropped without ack or kill");

  ////////////////////////////////////////////////////////////
  // done state
  ////////////////////////////////////////////////////////////

  // single cycle and entered only from an acked request
  done_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    done_i |=> !done_i
  ) else $error("done state held longer than one cycle");

  done_after_ack: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(done_i) |-> $past(req_i && ack_i)
  ) else $error("done state entered without an ack");

endmodule

bind irq_int_controller irq_subsys_assertions u_ctrl_assertions (
  .clk    (clk),
  .rst_n  (rst_n),
  .req_i  (irq_req_ctrl_o),
  .ack_i  (ctrl_ack_i),
  .kill_i (ctrl_kill_i),
  .done_i (state_q == irq_pkg::IRQ_DONE)
);

// the registered trap strobe marks completion on the trap side
bind irq_trap_ctrl irq_subsys_assertions u_trap_assertions (
  .clk    (clk),
  .rst_n  (rst_n),
  .req_i  (irq_req_ctrl_i),
  .ack_i  (ctrl_ack_o),
  .kill_i (ctrl_kill_o),
  .done_i (trap_valid_o)
);

// File: tb/irq_subsys_tb.sv
`timescale 1ns/1ps

module irq_subsys_tb;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int RST_CYCLES = 5;
  localparam int SLACK      = 50;
  localparam int MAX_REC    = 64;

  // DUT inputs
  logic                        clk;
  logic                        rst_n;
  logic [irq_pkg::IRQ_NUM-1:0] irq_lines;
  logic                        busy;
  logic                        flush;
  logic [31:0]                 pc;
  logic                        mret;
  logic                        csr_we;
  irq_pkg::csr_addr_e          csr_addr;
  logic [31:0]                 csr_wdata;
  // DUT outputs
  logic [31:0]                 csr_rdata;
  logic                        trap_valid;
  logic [31:0]                 trap_target;
  logic [4:0]                  trap_cause;
  irq_pkg::priv_lvl_e          priv_lvl;

  // record table with one entry per data file line
  logic [8*24-1:0] rec_name   [MAX_REC];
  logic [31:0]     rec_cycles [MAX_REC];
  logic [31:0]     rec_lines  [MAX_REC];
  logic [31:0]     rec_busy   [MAX_REC];
  logic [31:0]     rec_flush  [MAX_REC];
  logic [31:0]     rec_pc     [MAX_REC];
  logic [31:0]     rec_mret   [MAX_REC];
  logic [31:0]     rec_we     [MAX_REC];
  logic [31:0]     rec_addr   [MAX_REC];
  logic [31:0]     rec_wdata  [MAX_REC];
  logic [31:0]     rec_traps  [MAX_REC];
  logic [31:0]     rec_tcyc   [MAX_REC];
  logic [31:0]     rec_target [MAX_REC];
  logic [31:0]     rec_cause  [MAX_REC];
  logic [31:0]     rec_priv   [MAX_REC];
  logic [31:0]     rec_rdata  [MAX_REC];
  int              rec_count;
  int              total_cycles;
  int              limit_ns;
  logic            limit_set;

  irq_subsys_top #(
    .SECURE_EN (1'b1)
  ) u_irq_subsys_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_lines_i   (irq_lines),
    .busy_i        (busy),
    .flush_i       (flush),
    .pc_i          (pc),
    .mret_i        (mret),
    .csr_we_i      (csr_we),
    .csr_addr_i    (csr_addr),
    .csr_wdata_i   (csr_wdata),
    .csr_rdata_o   (csr_rdata),
    .trap_valid_o  (trap_valid),
    .trap_target_o (trap_target),
    .trap_cause_o  (trap_cause),
    .priv_lvl_o    (priv_lvl)
  );

  ////////////////////////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // limit is known once the record lengths are summed
  initial
  begin
    wait (limit_set);
    #(limit_ns);
    $display("timeout: run still going after %0d ns", limit_ns);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(
    input logic [8*24-1:0] test_name,
    input string           what,
    input logic [31:0]     expected,
    input logic [31:0]     actual
  );
    if (actual !== expected)
    begin
      $display("Error: test %0s, %0s expected 0x%08h actual 0x%08h",
               test_name, what, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic load_records();
    int    fd;
    int    n;
    string line;
    fd = $fopen("tb/irq_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file tb/irq_input.txt");
      $display("TESTS FAILED");
      $fatal(1, "missing stimulus file");
    end
    else
    begin
      rec_count    = 0;
      total_cycles = 0;
      while ($fgets(line, fd) != 0)
      begin
        // skip comment and blank lines
        if (line.len() < 2 || line.getc(0) == "#")
        begin
          continue;
        end
        n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %d %d %h %h %h %h",
                    rec_name[rec_count], rec_cycles[rec_count], rec_lines[rec_count],
                    rec_busy[rec_count], rec_flush[rec_count], rec_pc[rec_count],
                    rec_mret[rec_count], rec_we[rec_count], rec_addr[rec_count],
                    rec_wdata[rec_count], rec_traps[rec_count], rec_tcyc[rec_count],
                    rec_target[rec_count], rec_cause[rec_count], rec_priv[rec_count],
                    rec_rdata[rec_count]);
        if (n != 16 || rec_count >= MAX_REC - 1)
        begin
          $display("stimulus file has a malformed record or too many records");
          $display("TESTS FAILED");
          $fatal(1, "bad stimulus file");
        end
        total_cycles += rec_cycles[rec_count];
        rec_count++;
      end
      $fclose(fd);
    end
  endtask

  // levels hold for the whole record while mret and the write pulse in cycle 0
  // trap strobe is watched every cycle
  task automatic run_record(input int idx);
    int          traps;
    int          first_cyc;
    logic [31:0] hit_target;
    logic [4:0]  hit_cause;
    logic [31:0] end_rdata;
    logic [1:0]  end_priv;
    traps      = 0;
    first_cyc  = -1;
    hit_target = '0;
    hit_cause  = '0;
    end_rdata  = '0;
    end_priv   = '0;
    for (int c = 0; c < int'(rec_cycles[idx]); c++)
    begin
      irq_lines = rec_lines[idx];
      busy      = rec_busy[idx][0];
      flush     = rec_flush[idx][0];
      pc        = rec_pc[idx];
      mret      = (c == 0) ? rec_mret[idx][0] : 1'b0;
      csr_we    = (c == 0) ? rec_we[idx][0] : 1'b0;
      csr_addr  = irq_pkg::csr_addr_e'(rec_addr[idx][2:0]);
      csr_wdata = rec_wdata[idx];
      // registered outputs have settled by mid-cycle
      @(negedge clk);
      if (trap_valid)
      begin
        if (traps == 0)
        begin
          first_cyc  = c;
          hit_target = trap_target;
          hit_cause  = trap_cause;
        end
        traps++;
      end
      end_rdata = csr_rdata;
      end_priv  = priv_lvl;
      @(posedge clk);
      #(DRIVE_DLY);
    end
    check_value(rec_name[idx], "trap count", rec_traps[idx], traps);
    if (rec_traps[idx] != 0)
    begin
      check_value(rec_name[idx], "first trap cycle", rec_tcyc[idx], first_cyc);
      check_value(rec_name[idx], "trap target", rec_target[idx], hit_target);
      check_value(rec_name[idx], "trap cause", rec_cause[idx], {27'b0, hit_cause});
    end
    check_value(rec_name[idx], "privilege", rec_priv[idx], {30'b0, end_priv});
    check_value(rec_name[idx], "csr read", rec_rdata[idx], end_rdata);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst_n     = 1'b0;
    irq_lines = '0;
    busy      = 1'b0;
    flush     = 1'b0;
    pc        = '0;
    mret      = 1'b0;
    csr_we    = 1'b0;
    csr_addr  = irq_pkg::CSR_STATUS;
    csr_wdata = '0;
    limit_set = 1'b0;
    load_records();
    limit_ns  = (total_cycles + SLACK) * CLK_PERIOD;
    limit_set = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;
    for (int i = 0; i < rec_count; i++)
    begin
      run_record(i);
    end
    if (rec_count > 0)
    begin
      $display("TESTS PASSED");
      $finish;
    end
    else
    begin
      $display("the stimulus file holds no record");
      $display("TESTS FAILED");
      $fatal(1, "run failed");
    end
  end

endmodule

// File: tb/irq_input.txt
# columns: name cycles lines busy flush pc mret we addr wdata
#   then expected: traps first_trap_cycle target cause priv rdata
# addr 0 status, 1 mtvec, 2 mepc, 3 mcause, 4 mask, 5 sec mask
# mret and the write act in cycle 0 only, the rest hold for the record
#
# setup of trap base, line mask and machine enable
set_mtvec      2 00000000 0 0 00000000 0 1 1 00001000 0 0 00000000 00 3 00001000
set_mask       2 00000000 0 0 00000000 0 1 4 0000ffff 0 0 00000000 00 3 0000ffff
set_mie        2 00000000 0 0 00000000 0 1 0 00001808 0 0 00000000 00 3 00001808
# lines 9 and 4 together, lowest id wins
prio_vec       6 00000210 0 0 80000100 0 0 2 00000000 1 2 00001010 04 3 80000100
stat_after     2 00000000 0 0 00000000 0 0 0 00000000 0 0 00000000 00 3 00001880
# no trap with mie clear or with the line masked
no_mie         5 00000001 0 0 00000000 0 0 0 00000000 0 0 00000000 00 3 00001880
set_mie_2      2 00000000 0 0 00000000 0 1 0 00001808 0 0 00000000 00 3 00001808
masked_line    5 00010000 0 0 00000000 0 0 4 00000000 0 0 00000000 00 3 0000ffff
# busy stretches the pending state
busy_hold      6 00000020 1 0 80000200 0 0 3 00000000 0 0 00000000 00 3 00000004
busy_release   4 00000020 0 0 80000204 0 0 2 00000000 1 1 00001014 05 3 80000204
set_mie_3      2 00000000 0 0 00000000 0 1 0 00001808 0 0 00000000 00 3 00001808
# flush kills, the line re-pends once flush drops
flush_kill     6 00000100 0 1 80000300 0 0 0 00000000 0 0 00000000 00 3 00001808
flush_release  5 00000100 0 0 80000300 0 0 3 00000000 1 2 00001020 08 3 00000008
# stacked status, mret and retrap on the held line
stat_stacked   3 00000100 0 0 00000000 0 0 0 00000000 0 0 00000000 00 3 00001880
mret_machine   2 00000100 0 0 00000000 1 0 0 00000000 0 0 00000000 00 3 00000088
retrap         4 00000100 0 0 80000400 0 0 2 00000000 1 1 00001020 08 3 80000400
# user mode with uie clear, only the secure line 10 passes
set_mpp_user   2 00000000 0 0 00000000 0 1 0 00000080 0 0 00000000 00 3 00000080
set_sec        2 00000000 0 0 00000000 0 1 5 00000400 0 0 00000000 00 3 00000400
mret_user      2 00000000 0 0 00000000 1 0 0 00000000 0 0 00000000 00 0 00000088
nonsec_user    5 00000800 0 0 00000000 0 0 0 00000000 0 0 00000000 00 0 00000088
sec_user       5 00000400 0 0 80000500 0 0 3 00000000 1 2 00001028 0a 3 0000000a
stat_final     3 00000000 0 0 00000000 0 0 0 00000000 0 0 00000000 00 3 00000080

// File: verilog.f
hdl/irq_pkg.sv
hdl/irq_line_arbiter.sv
hdl/irq_int_controller.sv
hdl/irq_csr_file.sv
hdl/irq_trap_ctrl.sv
hdl/irq_subsys_top.sv
tb/irq_subsys_assertions.sv
tb/irq_subsys_tb.sv

// File: Bender.yml
package:
  name: irq_subsys

sources:
  # RTL, package first
  - hdl/irq_pkg.sv
  - hdl/irq_line_arbiter.sv
  - hdl/irq_int_controller.sv
  - hdl/irq_csr_file.sv
  - hdl/irq_trap_ctrl.sv
  - hdl/irq_subsys_top.sv

  # testbench with bound assertions
  - target: test
    files:
      - tb/irq_subsys_assertions.sv
      - tb/irq_subsys_tb.sv

# top modules: irq_subsys_tb for simulation, irq_subsys_top for synthesis
